// ==== trace_pkg.sv ====
//////////////////////////////
// trace port, rule and record sizes
// port fixed at 4 bits, four rules over a 32-bit history
// record packs rule index above a 16-bit nibble timestamp
//////////////////////////////
`default_nettype none

package trace_pkg;

   localparam int NIBBLE_W   = 4;   // trace port width
   localparam int NUM_RULES  = 4;
   localparam int BUF_W      = 32;  // history buffer
   localparam int COUNT_W    = 8;   // saturating hit counters
   localparam int TS_W       = 16;
   localparam int FIFO_DEPTH = 16;

   localparam int RULE_IDX_W = $clog2(NUM_RULES);
   localparam int REC_W      = RULE_IDX_W + TS_W;
   localparam int LEVEL_W    = $clog2(FIFO_DEPTH) + 1;

   typedef logic [NIBBLE_W-1:0]   nibble_t;
   typedef logic [BUF_W-1:0]      pattern_t;    // pattern, mask or history
   typedef logic [NUM_RULES-1:0]  rule_vec_t;
   typedef logic [RULE_IDX_W-1:0] rule_idx_t;
   typedef logic [COUNT_W-1:0]    hit_count_t;
   typedef logic [TS_W-1:0]       timestamp_t;  // nibbles since arm
   typedef logic [REC_W-1:0]      record_t;     // {rule index, timestamp}
   typedef logic [LEVEL_W-1:0]    fifo_count_t;

   typedef enum logic [1:0] {
      CAP_IDLE,
      CAP_RUN,
      CAP_DONE
   } capture_state_t;

endpackage

`default_nettype wire

// ==== reg_pkg.sv ====
//////////////////////////////
// APB register map, byte addressed
// per-rule words sit at base + 4*rule
// arm bit is a strobe and reads back 0
//////////////////////////////
`default_nettype none

package reg_pkg;

   typedef logic [7:0]  apb_addr_t;
   typedef logic [31:0] apb_data_t;
   typedef logic [15:0] delay_t;
   typedef logic [7:0]  width_t;
   typedef logic [15:0] cap_len_t;

   localparam apb_addr_t ADDR_CTRL         = 8'h00;
   localparam apb_addr_t ADDR_STATUS       = 8'h04;  // read only
   localparam apb_addr_t ADDR_CAP_LEN      = 8'h08;
   localparam apb_addr_t ADDR_TRIG_DELAY   = 8'h0C;
   localparam apb_addr_t ADDR_TRIG_WIDTH   = 8'h10;
   localparam apb_addr_t ADDR_FIFO_DATA    = 8'h14;  // read pops a record
   localparam apb_addr_t ADDR_PATTERN_BASE = 8'h20;
   localparam apb_addr_t ADDR_MASK_BASE    = 8'h30;
   localparam apb_addr_t ADDR_COUNT_BASE   = 8'h40;  // read only

   localparam int CTRL_ARM_BIT     = 0;
   localparam int CTRL_RULE_EN_LSB = 4;
   localparam int CTRL_TRIG_EN_LSB = 8;

   localparam int STAT_CAPTURING_BIT = 0;
   localparam int STAT_DONE_BIT      = 1;
   localparam int STAT_EMPTY_BIT     = 2;
   localparam int STAT_OVERFLOW_BIT  = 3;
   localparam int STAT_LEVEL_LSB     = 8;

endpackage

`default_nettype wire

// ==== trace_regs.sv ====
//////////////////////////////
// APB slave, zero wait states except FIFO data reads
// FIFO data read adds one wait cycle, pop at its edge
// unmapped addresses give pslverr with zero data
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module trace_regs
   import trace_pkg::*;
   import reg_pkg::*;
(
   input  wire logic       trace_clk,
   input  wire logic       reset,
   input  wire logic       psel,
   input  wire logic       penable,
   input  wire logic       pwrite,
   input  wire apb_addr_t  paddr,
   input  wire apb_data_t  pwdata,
   output apb_data_t       prdata,
   output logic            pready,
   output logic            pslverr,
   output rule_vec_t       rule_en,
   output rule_vec_t       trig_en,
   output pattern_t        pattern_0,
   output pattern_t        pattern_1,
   output pattern_t        pattern_2,
   output pattern_t        pattern_3,
   output pattern_t        mask_0,
   output pattern_t        mask_1,
   output pattern_t        mask_2,
   output pattern_t        mask_3,
   output cap_len_t        cap_len,
   output delay_t          trig_delay,
   output width_t          trig_width,
   output logic            arm_pulse,
   output logic            fifo_pop,
   input  wire hit_count_t hit_count_0,
   input  wire hit_count_t hit_count_1,
   input  wire hit_count_t hit_count_2,
   input  wire hit_count_t hit_count_3,
   input  wire capture_state_t cap_state,
   input  wire record_t    rd_record,
   input  wire logic       fifo_empty,
   input  wire fifo_count_t fifo_level,
   input  wire logic       overflow
);

   pattern_t   pattern_r [NUM_RULES];
   pattern_t   mask_r [NUM_RULES];
   hit_count_t counts [NUM_RULES];
   apb_data_t  rd_data;
   logic       access;
   logic       wr_en;
   logic       is_fifo_rd;
   logic       fifo_wait;
   logic       unmapped;
   logic       rule_word;  // aligned word in a per-rule page
   rule_idx_t  idx;

   assign access     = psel & penable;
   assign wr_en      = access & pwrite;
   assign is_fifo_rd = ~pwrite && (paddr == ADDR_FIFO_DATA);
   assign idx        = paddr[2 +: RULE_IDX_W];
   assign rule_word  = (paddr[1:0] == 2'b00);

   assign fifo_pop  = access & is_fifo_rd & ~fifo_wait;  // first access cycle
   assign pready    = access & (~is_fifo_rd | fifo_wait);
   assign pslverr   = pready & unmapped;
   assign prdata    = (access && !unmapped) ? rd_data : '0;
   assign arm_pulse = wr_en && (paddr == ADDR_CTRL) && pwdata[CTRL_ARM_BIT];

   assign counts[0] = hit_count_0;
   assign counts[1] = hit_count_1;
   assign counts[2] = hit_count_2;
   assign counts[3] = hit_count_3;

   assign pattern_0 = pattern_r[0];
   assign pattern_1 = pattern_r[1];
   assign pattern_2 = pattern_r[2];
   assign pattern_3 = pattern_r[3];
   assign mask_0    = mask_r[0];
   assign mask_1    = mask_r[1];
   assign mask_2    = mask_r[2];
   assign mask_3    = mask_r[3];

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         fifo_wait <= 1'b0;
      end else begin
         fifo_wait <= fifo_pop;  // record lands in rd_record at this edge
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         rule_en    <= '0;
         trig_en    <= '0;
         cap_len    <= '0;
         trig_delay <= '0;
         trig_width <= width_t'(1);
      end else if (wr_en) begin
         case (paddr)
            ADDR_CTRL: begin
               rule_en <= pwdata[CTRL_RULE_EN_LSB +: NUM_RULES];
               trig_en <= pwdata[CTRL_TRIG_EN_LSB +: NUM_RULES];
            end
            ADDR_CAP_LEN:    cap_len    <= cap_len_t'(pwdata);
            ADDR_TRIG_DELAY: trig_delay <= delay_t'(pwdata);
            ADDR_TRIG_WIDTH: trig_width <= width_t'(pwdata);
            default: ;  // read-only or per-rule words
         endcase
      end
   end

   always_ff @(posedge trace_clk) begin
      if (wr_en && rule_word) begin
         if (paddr[7:4] == ADDR_PATTERN_BASE[7:4])
            pattern_r[idx] <= pwdata;
         if (paddr[7:4] == ADDR_MASK_BASE[7:4])
            mask_r[idx] <= pwdata;
      end
   end

   always_comb begin
      rd_data  = '0;
      unmapped = 1'b0;
      if (rule_word && paddr[7:4] == ADDR_PATTERN_BASE[7:4]) begin
         rd_data = pattern_r[idx];
      end else if (rule_word && paddr[7:4] == ADDR_MASK_BASE[7:4]) begin
         rd_data = mask_r[idx];
      end else if (rule_word && paddr[7:4] == ADDR_COUNT_BASE[7:4]) begin
         rd_data = apb_data_t'(counts[idx]);
      end else begin
         case (paddr)
            ADDR_CTRL: begin
               rd_data[CTRL_RULE_EN_LSB +: NUM_RULES] = rule_en;
               rd_data[CTRL_TRIG_EN_LSB +: NUM_RULES] = trig_en;
            end
            ADDR_STATUS: begin
               rd_data[STAT_CAPTURING_BIT] = (cap_state == CAP_RUN);
               rd_data[STAT_DONE_BIT]      = (cap_state == CAP_DONE);
               rd_data[STAT_EMPTY_BIT]     = fifo_empty;
               rd_data[STAT_OVERFLOW_BIT]  = overflow;
               rd_data[STAT_LEVEL_LSB +: LEVEL_W] = fifo_level;
            end
            ADDR_CAP_LEN:    rd_data = apb_data_t'(cap_len);
            ADDR_TRIG_DELAY: rd_data = apb_data_t'(trig_delay);
            ADDR_TRIG_WIDTH: rd_data = apb_data_t'(trig_width);
            ADDR_FIFO_DATA:  rd_data = apb_data_t'(rd_record);
            default:         unmapped = 1'b1;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== trace_matcher.sv ====
//////////////////////////////
// history shifts left, newest nibble lowest
// match_hit valid one cycle after the accept edge
// counters saturate and clear on arm
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module trace_matcher
   import trace_pkg::*;
(
   input  wire logic      trace_clk,
   input  wire logic      reset,
   input  wire logic      trace_en,
   input  wire nibble_t   trace_data,
   input  wire rule_vec_t rule_en,
   input  wire pattern_t  pattern_0,
   input  wire pattern_t  pattern_1,
   input  wire pattern_t  pattern_2,
   input  wire pattern_t  pattern_3,
   input  wire pattern_t  mask_0,
   input  wire pattern_t  mask_1,
   input  wire pattern_t  mask_2,
   input  wire pattern_t  mask_3,
   input  wire logic      arm_pulse,
   output rule_vec_t      match_hit,
   output hit_count_t     hit_count_0,
   output hit_count_t     hit_count_1,
   output hit_count_t     hit_count_2,
   output hit_count_t     hit_count_3
);

   pattern_t   history;
   pattern_t   patterns [NUM_RULES];
   pattern_t   masks [NUM_RULES];
   hit_count_t counts [NUM_RULES];
   rule_vec_t  cmp;
   logic       accepted;  // history changed last edge

   assign patterns = '{pattern_0, pattern_1, pattern_2, pattern_3};
   assign masks    = '{mask_0, mask_1, mask_2, mask_3};

   always_comb begin
      for (int r = 0; r < NUM_RULES; r++)
         cmp[r] = ((history ^ patterns[r]) & masks[r]) == '0;  // mask 1 = compare
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         history   <= '0;
         accepted  <= 1'b0;
         match_hit <= '0;
      end else begin
         if (trace_en)
            history <= {history[BUF_W-NIBBLE_W-1:0], trace_data};
         accepted  <= trace_en;
         match_hit <= accepted ? (cmp & rule_en) : '0;
      end
   end

   always_ff @(posedge trace_clk) begin
      for (int r = 0; r < NUM_RULES; r++) begin
         if (reset || arm_pulse)
            counts[r] <= '0;
         else if (match_hit[r] && counts[r] != '1)
            counts[r] <= counts[r] + 1'b1;
      end
   end

   assign hit_count_0 = counts[0];
   assign hit_count_1 = counts[1];
   assign hit_count_2 = counts[2];
   assign hit_count_3 = counts[3];

endmodule

`default_nettype wire

// ==== capture_seq.sv ====
//////////////////////////////
// arm restarts from any state and clears the FIFO
// one record per hit cycle, lowest rule index wins
// dropped records still count toward cap_len
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module capture_seq
   import trace_pkg::*;
   import reg_pkg::*;
(
   input  wire logic      trace_clk,
   input  wire logic      reset,
   input  wire logic      trace_en,
   input  wire rule_vec_t match_hit,
   input  wire logic      arm_pulse,
   input  wire cap_len_t  cap_len,
   output capture_state_t cap_state,
   output logic           fifo_push,
   output record_t        fifo_record,
   output logic           fifo_clear
);

   timestamp_t timestamp;
   timestamp_t hit_ts;    // count as of the nibble behind match_hit
   cap_len_t   rec_cnt;
   cap_len_t   rec_cnt_nxt;
   rule_idx_t  hit_idx;

   always_comb begin
      hit_idx = '0;
      for (int r = NUM_RULES - 1; r >= 0; r--) begin
         if (match_hit[r])
            hit_idx = rule_idx_t'(r);
      end
   end

   assign fifo_clear  = arm_pulse;
   assign fifo_push   = (cap_state == CAP_RUN) && (|match_hit) && !arm_pulse;
   assign fifo_record = {hit_idx, hit_ts};
   assign rec_cnt_nxt = rec_cnt + cap_len_t'(fifo_push);

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         cap_state <= CAP_IDLE;
         timestamp <= '0;
         hit_ts    <= '0;
         rec_cnt   <= '0;
      end else begin
         hit_ts <= timestamp;  // lines up with match_hit
         if (arm_pulse) begin
            cap_state <= CAP_RUN;
            timestamp <= '0;
            rec_cnt   <= '0;
         end else begin
            case (cap_state)
               CAP_RUN: begin
                  if (trace_en)
                     timestamp <= timestamp + 1'b1;  // wraps
                  rec_cnt <= rec_cnt_nxt;
                  if (rec_cnt_nxt >= cap_len)
                     cap_state <= CAP_DONE;
               end
               CAP_DONE: cap_state <= CAP_DONE;
               default:  cap_state <= CAP_IDLE;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== event_fifo.sv ====
//////////////////////////////
// 16-entry record FIFO, registered read data
// push when full is dropped and sets overflow
// pop when empty keeps the last record
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module event_fifo
   import trace_pkg::*;
(
   input  wire logic    trace_clk,
   input  wire logic    reset,
   input  wire logic    fifo_push,
   input  wire record_t fifo_record,
   input  wire logic    fifo_clear,
   input  wire logic    fifo_pop,
   output record_t      rd_record,
   output logic         fifo_empty,
   output logic         fifo_full,
   output fifo_count_t  fifo_level,
   output logic         overflow
);

   localparam int AW = $clog2(FIFO_DEPTH);

   record_t        mem [FIFO_DEPTH];
   logic [AW-1:0]  wr_ptr;
   logic [AW-1:0]  rd_ptr;
   logic           do_push;
   logic           do_pop;

   assign fifo_empty = (fifo_level == '0);
   assign fifo_full  = (fifo_level == fifo_count_t'(FIFO_DEPTH));
   assign do_push    = fifo_push & ~fifo_full;
   assign do_pop     = fifo_pop & ~fifo_empty;

   always_ff @(posedge trace_clk) begin
      if (reset || fifo_clear) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fifo_level <= '0;
         overflow   <= 1'b0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         fifo_level <= fifo_level + fifo_count_t'(do_push) - fifo_count_t'(do_pop);
         if (fifo_push && fifo_full)
            overflow <= 1'b1;  // sticky
      end
   end

   always_ff @(posedge trace_clk) begin
      if (do_push)
         mem[wr_ptr] <= fifo_record;
      if (do_pop)
         rd_record <= mem[rd_ptr];
   end

endmodule

`default_nettype wire

// ==== trig_pulse.sv ====
//////////////////////////////
// one pulse per event, hits ignored while busy
// rises trig_delay+2 cycles after the accept edge
// width 0 is treated as 1
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module trig_pulse
   import trace_pkg::*;
   import reg_pkg::*;
(
   input  wire logic      trace_clk,
   input  wire logic      reset,
   input  wire rule_vec_t match_hit,
   input  wire rule_vec_t trig_en,
   input  wire delay_t    trig_delay,
   input  wire width_t    trig_width,
   output logic           trig_out
);

   typedef enum logic [1:0] {
      TRIG_IDLE,
      TRIG_DELAY,
      TRIG_HIGH
   } trig_state_t;

   trig_state_t state;
   delay_t      cnt;
   delay_t      high_len;  // width minus one
   logic        fire;

   assign fire     = |(match_hit & trig_en);
   assign high_len = (trig_width == '0) ? '0 : delay_t'(trig_width) - 1'b1;
   assign trig_out = (state == TRIG_HIGH);

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         state <= TRIG_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            TRIG_IDLE: begin
               if (fire && trig_delay == '0) begin
                  state <= TRIG_HIGH;
                  cnt   <= high_len;
               end else if (fire) begin
                  state <= TRIG_DELAY;
                  cnt   <= trig_delay - 1'b1;
               end
            end
            TRIG_DELAY: begin
               if (cnt == '0) begin
                  state <= TRIG_HIGH;
                  cnt   <= high_len;
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            TRIG_HIGH: begin
               if (cnt == '0)
                  state <= TRIG_IDLE;
               else
                  cnt <= cnt - 1'b1;
            end
            default: state <= TRIG_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== trace_capture_top.sv ====
//////////////////////////////
// single clock, APB controlled trace capture
// trace input never stalls, a full FIFO drops records
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module trace_capture_top
   import trace_pkg::*;
   import reg_pkg::*;
(
   input  wire logic      trace_clk,
   input  wire logic      reset,
   input  wire logic      trace_en,
   input  wire nibble_t   trace_data,
   input  wire logic      psel,
   input  wire logic      penable,
   input  wire logic      pwrite,
   input  wire apb_addr_t paddr,
   input  wire apb_data_t pwdata,
   output apb_data_t      prdata,
   output logic           pready,
   output logic           pslverr,
   output logic           trig_out,
   output logic           capturing
);

   rule_vec_t      rule_en, trig_en, match_hit;
   pattern_t       pattern_0, pattern_1, pattern_2, pattern_3;
   pattern_t       mask_0, mask_1, mask_2, mask_3;
   hit_count_t     hit_count_0, hit_count_1, hit_count_2, hit_count_3;
   cap_len_t       cap_len;
   delay_t         trig_delay;
   width_t         trig_width;
   logic           arm_pulse, fifo_pop, fifo_push, fifo_clear;
   logic           fifo_empty, fifo_full, overflow;
   capture_state_t cap_state;
   record_t        fifo_record, rd_record;
   fifo_count_t    fifo_level;

   assign capturing = (cap_state == CAP_RUN);

   trace_regs i_regs (
      .trace_clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
      .prdata, .pready, .pslverr, .rule_en, .trig_en,
      .pattern_0, .pattern_1, .pattern_2, .pattern_3,
      .mask_0, .mask_1, .mask_2, .mask_3,
      .cap_len, .trig_delay, .trig_width, .arm_pulse, .fifo_pop,
      .hit_count_0, .hit_count_1, .hit_count_2, .hit_count_3,
      .cap_state, .rd_record, .fifo_empty, .fifo_level, .overflow
   );

   trace_matcher i_matcher (
      .trace_clk, .reset, .trace_en, .trace_data, .rule_en,
      .pattern_0, .pattern_1, .pattern_2, .pattern_3,
      .mask_0, .mask_1, .mask_2, .mask_3, .arm_pulse, .match_hit,
      .hit_count_0, .hit_count_1, .hit_count_2, .hit_count_3
   );

   capture_seq i_seq (
      .trace_clk, .reset, .trace_en, .match_hit, .arm_pulse, .cap_len,
      .cap_state, .fifo_push, .fifo_record, .fifo_clear
   );

   event_fifo i_fifo (
      .trace_clk, .reset, .fifo_push, .fifo_record, .fifo_clear, .fifo_pop,
      .rd_record, .fifo_empty, .fifo_full, .fifo_level, .overflow
   );

   trig_pulse i_trig (
      .trace_clk, .reset, .match_hit, .trig_en, .trig_delay, .trig_width,
      .trig_out
   );

endmodule

`default_nettype wire

// ==== trace_capture_chk.sv ====
//////////////////////////////
// assertions bound into trace_capture_top
// pulse length compared with the width register
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module trace_capture_chk
   import trace_pkg::*;
   import reg_pkg::*;
(
   input wire logic        trace_clk,
   input wire logic        reset,
   input wire logic        psel,
   input wire logic        penable,
   input wire logic        pready,
   input wire fifo_count_t fifo_level,
   input wire logic        fifo_full,
   input wire logic        overflow,
   input wire logic        trig_out,
   input wire width_t      trig_width
);

   logic [8:0]  high_run;  // edges with trig_out high in a row
   int unsigned fail_count = 0;  // failed assertions so far

   always_ff @(posedge trace_clk) begin
      if (reset || !trig_out)
         high_run <= '0;
      else
         high_run <= high_run + 1'b1;
   end

   pready_in_access: assert property (@(posedge trace_clk) disable iff (reset)
      pready |-> (psel && penable))
      else begin
         $error("pready high outside an APB access phase");
         fail_count++;
      end

   fifo_level_bound: assert property (@(posedge trace_clk) disable iff (reset)
      fifo_level <= fifo_count_t'(FIFO_DEPTH))
      else begin
         $error("FIFO level beyond its depth");
         fail_count++;
      end

   overflow_when_full: assert property (@(posedge trace_clk) disable iff (reset)
      $rose(overflow) |-> $past(fifo_full))
      else begin
         $error("overflow set while the FIFO had room");
         fail_count++;
      end

   trig_width_bound: assert property (@(posedge trace_clk) disable iff (reset)
      high_run <= ((trig_width == '0) ? 9'd1 : {1'b0, trig_width}))
      else begin
         $error("trigger pulse longer than trig_width");
         fail_count++;
      end

endmodule

bind trace_capture_top trace_capture_chk i_chk (
   .trace_clk, .reset, .psel, .penable, .pready, .fifo_level, .fifo_full, .overflow,
   .trig_out, .trig_width
);

`default_nettype wire

// ==== tb_trace_capture.sv ====
//////////////////////////////
// testbench for trace_capture_top, seed 62301
// model keeps every nibble since reset, history is never cleared
// trig_out compared every cycle at the falling edge
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_trace_capture
   import trace_pkg::*;
   import reg_pkg::*;
();

   localparam int STIM_CYCLES = 1100;
   localparam int READ_CYCLES = 600;
   localparam int CYC_LIMIT   = 2 * (STIM_CYCLES + READ_CYCLES) + 500;

   logic      trace_clk, reset, trace_en, psel, penable, pwrite;
   logic      pready, pslverr, trig_out, capturing;
   nibble_t   trace_data;
   apb_addr_t paddr;
   apb_data_t pwdata, prdata;

   nibble_t   nib_q [$];          // every accepted nibble
   record_t   exp_rec [$];
   int        exp_cnt [NUM_RULES];
   pattern_t  pat_m [NUM_RULES];
   pattern_t  msk_m [NUM_RULES];
   rule_vec_t rule_en_m, trig_en_m;
   int        cap_len_m, delay_m, width_m;
   int        arm_pos, trig_free_at;  // edge where the pulse ends
   bit        exp_trig [0:CYC_LIMIT];
   int        cyc, errors, checks, seed;
   apb_data_t rd;
   logic      err;

   trace_capture_top i_dut (
      .trace_clk, .reset, .trace_en, .trace_data, .psel, .penable, .pwrite,
      .paddr, .pwdata, .prdata, .pready, .pslverr, .trig_out, .capturing
   );

   always #20 trace_clk = ~trace_clk;

   always @(posedge trace_clk) begin
      cyc <= cyc + 1;
      if (cyc == CYC_LIMIT) begin
         $display("timeout: test did not finish within %0d cycles", CYC_LIMIT);
         $display("Simulation failed");
         $finish;
      end
   end

   always @(negedge trace_clk) begin
      if (cyc > 0)
         check("trig_out", apb_data_t'(exp_trig[cyc]), apb_data_t'(trig_out));
   end

   task automatic check(input string name, input apb_data_t exp, input apb_data_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, act);
      end
   endtask

   // masked compare of the last eight nibbles up to pos
   function automatic rule_vec_t match_rules(int pos);
      pattern_t  hist;
      rule_vec_t hit;
      hist = '0;
      for (int j = 0; j < BUF_W / NIBBLE_W; j++) begin
         if (pos - j >= 0)
            hist[j*NIBBLE_W +: NIBBLE_W] = nib_q[pos - j];
      end
      for (int r = 0; r < NUM_RULES; r++)
         hit[r] = rule_en_m[r] && (((hist ^ pat_m[r]) & msk_m[r]) == '0);
      return hit;
   endfunction

   function automatic void build_expected();
      rule_vec_t hit;
      rule_idx_t low;
      exp_rec.delete();
      for (int r = 0; r < NUM_RULES; r++)
         exp_cnt[r] = 0;
      for (int p = arm_pos; p < nib_q.size(); p++) begin
         hit = match_rules(p);
         low = '0;
         for (int r = NUM_RULES - 1; r >= 0; r--) begin
            if (hit[r])
               low = rule_idx_t'(r);
            if (hit[r] && exp_cnt[r] < (1 << COUNT_W) - 1)
               exp_cnt[r]++;
         end
         if (hit != '0 && exp_rec.size() < cap_len_m)
            exp_rec.push_back({low, timestamp_t'(p - arm_pos + 1)});  // count incl. this one
      end
   endfunction

   function automatic apb_data_t status_word(bit done, int level, bit ovf);
      apb_data_t s;
      s = '0;
      s[STAT_CAPTURING_BIT] = !done;
      s[STAT_DONE_BIT]      = done;
      s[STAT_EMPTY_BIT]     = (level == 0);
      s[STAT_OVERFLOW_BIT]  = ovf;
      s[STAT_LEVEL_LSB +: LEVEL_W] = fifo_count_t'(level);
      return s;
   endfunction

   task automatic bus_transfer(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                               output apb_data_t rdata, output logic slverr);
      @(posedge trace_clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge trace_clk);
      penable <= 1'b1;
      do @(posedge trace_clk); while (!pready);  // FIFO reads take one more
      rdata  = prdata;
      slverr = pslverr;
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
      apb_data_t unused;
      logic      e;
      bus_transfer(addr, 1'b1, data, unused, e);
      check("pslverr", '0, apb_data_t'(e));
   endtask

   task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
      logic e;
      bus_transfer(addr, 1'b0, '0, data, e);
      check("pslverr", '0, apb_data_t'(e));
   endtask

   task automatic set_rule(input int r, input pattern_t p, input pattern_t m);
      write_reg(ADDR_PATTERN_BASE + apb_addr_t'(4 * r), p);
      write_reg(ADDR_MASK_BASE + apb_addr_t'(4 * r), m);
      pat_m[r] = p;
      msk_m[r] = m;
   endtask

   task automatic set_trigger(input int d, input int w);
      write_reg(ADDR_TRIG_DELAY, d);
      write_reg(ADDR_TRIG_WIDTH, w);
      delay_m = d;
      width_m = w;
   endtask

   task automatic arm_capture(input rule_vec_t ren, input rule_vec_t ten, input int len);
      write_reg(ADDR_CAP_LEN, len);
      write_reg(ADDR_CTRL, (apb_data_t'(ten) << CTRL_TRIG_EN_LSB) |
                (apb_data_t'(ren) << CTRL_RULE_EN_LSB) | (1 << CTRL_ARM_BIT));
      cap_len_m = len;
      rule_en_m = ren;
      trig_en_m = ten;
      arm_pos   = nib_q.size();
   endtask

   task automatic put_nibble(input nibble_t n);
      int accept;
      int rise;
      @(posedge trace_clk);
      trace_en   <= 1'b1;
      trace_data <= n;
      accept = cyc + 2;  // edge that takes this nibble
      nib_q.push_back(n);
      if ((match_rules(nib_q.size() - 1) & trig_en_m) != '0 && accept + 2 > trig_free_at) begin
         rise = accept + delay_m + 2;
         for (int k = 0; k < width_m; k++)
            exp_trig[rise + k] = 1'b1;
         trig_free_at = rise + width_m;
      end
   endtask

   task automatic put_pattern(input pattern_t p);
      for (int j = BUF_W / NIBBLE_W - 1; j >= 0; j--)
         put_nibble(p[j*NIBBLE_W +: NIBBLE_W]);
   endtask

   task automatic idle_cycles(input int k);
      repeat (k) begin
         @(posedge trace_clk);
         trace_en <= 1'b0;
      end
   endtask

   task automatic stream_random(input int n);
      int sent;
      int sel;
      sent = 0;
      while (sent < n) begin
         sel = $random(seed) & 7;
         if (sel < 2) begin
            put_pattern((pat_m[sel] & msk_m[sel]) | (pattern_t'($random(seed)) & ~msk_m[sel]));
            sent += BUF_W / NIBBLE_W;
         end else if (sel == 2) begin
            idle_cycles(1);  // gap in the stream
         end else begin
            put_nibble(nibble_t'($random(seed)));
            sent++;
         end
      end
      idle_cycles(1);
   endtask

   task automatic check_capture();
      apb_data_t data;
      int        nrec;
      int        nkeep;
      bit        done;
      idle_cycles(4);  // let the last hits reach the FIFO
      build_expected();
      nrec  = exp_rec.size();
      nkeep = (nrec > FIFO_DEPTH) ? FIFO_DEPTH : nrec;
      done  = (nrec >= cap_len_m);
      for (int r = 0; r < NUM_RULES; r++) begin
         read_reg(ADDR_COUNT_BASE + apb_addr_t'(4 * r), data);
         check($sformatf("hit_count_%0d", r), exp_cnt[r], data);
      end
      read_reg(ADDR_STATUS, data);
      check("status", status_word(done, nkeep, nrec > FIFO_DEPTH), data);
      check("capturing", apb_data_t'(!done), apb_data_t'(capturing));
      for (int i = 0; i < nkeep; i++) begin
         read_reg(ADDR_FIFO_DATA, data);
         check("fifo_data", exp_rec[i], data);
      end
      read_reg(ADDR_STATUS, data);
      check("status", status_word(done, 0, nrec > FIFO_DEPTH), data);
   endtask

   initial begin
      seed = 62301;
      cyc = 0;
      errors = 0;
      checks = 0;
      trig_free_at = 0;
      trace_clk = 1'b0;
      reset = 1'b1;
      trace_en = 1'b0;
      trace_data = '0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      repeat (3) @(posedge trace_clk);
      reset <= 1'b0;

      check("capturing", '0, apb_data_t'(capturing));
      read_reg(ADDR_STATUS, rd);
      check("status", apb_data_t'(1) << STAT_EMPTY_BIT, rd);  // idle and empty
      for (int r = 0; r < NUM_RULES; r++) begin
         read_reg(ADDR_COUNT_BASE + apb_addr_t'(4 * r), rd);
         check($sformatf("hit_count_%0d", r), '0, rd);
      end

      set_rule(0, 32'hC0FFEE42, 32'hFFFFFFFF);
      set_rule(1, 32'h9E0037B0, 32'hFF00FFF0);  // gaps in the middle and low nibble
      set_rule(2, 32'h000000D6, 32'h000000FF);
      set_rule(3, 32'h00000003, 32'h00000000);  // hits every nibble
      write_reg(ADDR_CAP_LEN, 12);
      set_trigger(5, 3);
      for (int r = 0; r < NUM_RULES; r++) begin
         read_reg(ADDR_PATTERN_BASE + apb_addr_t'(4 * r), rd);
         check("pattern", pat_m[r], rd);
         read_reg(ADDR_MASK_BASE + apb_addr_t'(4 * r), rd);
         check("mask", msk_m[r], rd);
      end
      read_reg(ADDR_CAP_LEN, rd);
      check("cap_len", 12, rd);
      read_reg(ADDR_TRIG_DELAY, rd);
      check("trig_delay", 5, rd);
      read_reg(ADDR_TRIG_WIDTH, rd);
      check("trig_width", 3, rd);
      bus_transfer(8'h7C, 1'b0, '0, rd, err);
      check("pslverr", 1, apb_data_t'(err));
      check("prdata", '0, rd);

      arm_capture(4'hF, 4'h0, 12);  // rule 3 saturates
      stream_random(300);
      check_capture();

      arm_capture(4'h7, 4'h0, 10);
      stream_random(300);
      check_capture();

      arm_capture(4'h7, 4'h0, 40);
      stream_random(300);
      check_capture();
      if (exp_rec.size() <= FIFO_DEPTH) begin
         errors++;
         $display("overflow test produced too few matches to fill the FIFO");
      end

      arm_capture(4'h1, 4'h1, 4);
      put_pattern(pat_m[0]);
      put_pattern(pat_m[0]);  // lands while the first pulse is pending
      idle_cycles(12);
      put_pattern(pat_m[0]);
      idle_cycles(20);
      check_capture();

      errors += i_dut.i_chk.fail_count;
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== trace_capture.f ====
trace_pkg.sv
reg_pkg.sv
trace_regs.sv
trace_matcher.sv
capture_seq.sv
event_fifo.sv
trig_pulse.sv
trace_capture_top.sv
trace_capture_chk.sv
tb_trace_capture.sv
